/* include/exu_cfg.svh */
// ======================================================================
// Width and step constants for the execute back end
// Included by the package and by every module that sizes its own logic
// ======================================================================
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// Data path
`define EXU_XLEN        64
`define EXU_WORD        32
`define EXU_REG_IDX_W   5

// Byte lanes of one data word
`define EXU_STRB_W      8
`define EXU_OFFS_W      3

// PC step for normal and compressed instructions
`define EXU_ILEN        4
`define EXU_CLEN        2

`endif

/* verilog/exu_pkg.sv */
// ======================================================================
// Shared types of the execute back end: opcodes, stage structs
// ======================================================================
`include "exu_cfg.svh"

package exu_pkg;

    typedef enum logic [1:0] {
        CLS_ALU = 2'd0,
        CLS_JBR = 2'd1,
        CLS_MEM = 2'd2
    } instr_cls_e;

    typedef enum logic [3:0] {
        ALS_ADD  = 4'd0,
        ALS_SUB  = 4'd1,
        ALS_SLL  = 4'd2,
        ALS_SRL  = 4'd3,
        ALS_SRA  = 4'd4,
        ALS_XOR  = 4'd5,
        ALS_OR   = 4'd6,
        ALS_AND  = 4'd7,
        ALS_SEQ  = 4'd8,
        ALS_SNE  = 4'd9,
        ALS_SLT  = 4'd10,
        ALS_SGE  = 4'd11,
        ALS_SLTU = 4'd12,
        ALS_SGEU = 4'd13
    } als_op_e;

    typedef enum logic [1:0] {
        JBR_JAL    = 2'd0,
        JBR_JALR   = 2'd1,
        JBR_BRANCH = 2'd2
    } jbr_kind_e;

    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'd0,
        SIZE_HALF   = 2'd1,
        SIZE_WORD   = 2'd2,
        SIZE_DOUBLE = 2'd3
    } size_e;

    typedef struct packed {
        logic  store;
        logic  sign_ext;
        size_e size;
    } mem_desc_t;

    // Same 4 bits, read by instruction class
    typedef union packed {
        als_op_e   als;
        mem_desc_t mem;
    } op_u;

    typedef struct packed {
        logic [`EXU_XLEN-1:0]      pc;
        logic [`EXU_XLEN-1:0]      npc;
        instr_cls_e                cls;
        op_u                       op;
        jbr_kind_e                 jbr;
        logic                      word;
        logic                      compressed;
        logic [`EXU_XLEN-1:0]      rs1;
        logic [`EXU_XLEN-1:0]      rs2;
        logic [`EXU_XLEN-1:0]      jbr_base;
        logic [`EXU_XLEN-1:0]      imm;
        logic [`EXU_XLEN-1:0]      st_data;
        logic                      rd_en;
        logic [`EXU_REG_IDX_W-1:0] rd_idx;
    } exu_instr_t;

    typedef struct packed {
        logic                   valid;
        logic                   we;
        logic [`EXU_XLEN-1:0]   addr;
        logic [`EXU_XLEN-1:0]   wdata;
        logic [`EXU_STRB_W-1:0] strb;
        size_e                  size;
    } dmem_req_t;

    typedef struct packed {
        logic                      ld_en;
        logic                      rd_en;
        logic [`EXU_REG_IDX_W-1:0] rd_idx;
        logic [`EXU_XLEN-1:0]      result;
        mem_desc_t                 ld_desc;
        logic [`EXU_OFFS_W-1:0]    offset;
    } mem_slot_t;

    typedef struct packed {
        logic                      we;
        logic [`EXU_REG_IDX_W-1:0] idx;
        logic [`EXU_XLEN-1:0]      data;
    } wb_t;

    typedef struct packed {
        logic                 valid;
        logic [`EXU_XLEN-1:0] pc;
        logic [`EXU_XLEN-1:0] npc;
    } mispred_t;

endpackage

/* verilog/exu_alu.sv */
// ======================================================================
// Algebra, logic, shift and compare unit, purely combinational
// Word mode narrows add, sub and shifts to 32 bits and sign-extends
// ======================================================================
`timescale 1ns/10ps
`include "exu_cfg.svh"

module exu_alu
    import exu_pkg::*;
(
    input  logic [`EXU_XLEN-1:0] a_i,
    input  logic [`EXU_XLEN-1:0] b_i,
    input  als_op_e              op_i,
    input  logic                 word_i,
    output logic [`EXU_XLEN-1:0] result_o
);

    logic [5:0]           shamt;
    logic [`EXU_WORD-1:0] res_w;
    logic [`EXU_XLEN-1:0] res_d;
    logic                 cmp;
    logic                 word_op;

    assign shamt = b_i[5:0];

    // 32-bit forms, shift amount limited to 5 bits
    always_comb begin
        case (op_i)
            ALS_SUB: res_w = a_i[`EXU_WORD-1:0] - b_i[`EXU_WORD-1:0];
            ALS_SLL: res_w = a_i[`EXU_WORD-1:0] << shamt[4:0];
            ALS_SRL: res_w = a_i[`EXU_WORD-1:0] >> shamt[4:0];
            ALS_SRA: res_w = $signed(a_i[`EXU_WORD-1:0]) >>> shamt[4:0];
            default: res_w = a_i[`EXU_WORD-1:0] + b_i[`EXU_WORD-1:0];
        endcase
    end

    // Compares, also used as the branch condition
    always_comb begin
        case (op_i)
            ALS_SEQ:  cmp = (a_i == b_i);
            ALS_SNE:  cmp = (a_i != b_i);
            ALS_SLT:  cmp = ($signed(a_i) < $signed(b_i));
            ALS_SGE:  cmp = ($signed(a_i) >= $signed(b_i));
            ALS_SLTU: cmp = (a_i < b_i);
            ALS_SGEU: cmp = (a_i >= b_i);
            default:  cmp = 1'b0;
        endcase
    end

    always_comb begin
        case (op_i)
            ALS_ADD: res_d = a_i + b_i;
            ALS_SUB: res_d = a_i - b_i;
            ALS_SLL: res_d = a_i << shamt;
            ALS_SRL: res_d = a_i >> shamt;
            ALS_SRA: res_d = $signed(a_i) >>> shamt;
            ALS_XOR: res_d = a_i ^ b_i;
            ALS_OR:  res_d = a_i | b_i;
            ALS_AND: res_d = a_i & b_i;
            default: res_d = {{(`EXU_XLEN-1){1'b0}}, cmp};
        endcase
    end

    // Only arithmetic and shifts have a word form
    assign word_op = (op_i inside {ALS_ADD, ALS_SUB, ALS_SLL, ALS_SRL, ALS_SRA});

    assign result_o = (word_i && word_op) ?
                      {{(`EXU_XLEN-`EXU_WORD){res_w[`EXU_WORD-1]}}, res_w} : res_d;

endmodule

/* verilog/exu_ex_stage.sv */
// ======================================================================
// EX0 stage: operation select, next-PC resolution, mispredict report
// and data memory request build, combinational from the input
// ======================================================================
`timescale 1ns/10ps
`include "exu_cfg.svh"

module exu_ex_stage
    import exu_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       in_valid_i,
    input  exu_instr_t in_instr_i,
    input  logic       in_ready_i,
    output mem_slot_t  slot_o,
    output logic       accept_o,
    output dmem_req_t  req_o,
    output mispred_t   mispred_o
);

    logic [`EXU_XLEN-1:0]   alu_res;
    als_op_e                alu_op;
    logic                   is_mem;
    logic                   is_jbr;
    logic                   is_store;
    logic                   taken;
    logic [`EXU_XLEN-1:0]   true_npc;
    logic [`EXU_OFFS_W-1:0] offset;
    logic [`EXU_STRB_W-1:0] strb_base;
    logic                   mp_valid_q;
    logic [`EXU_XLEN-1:0]   mp_pc_q;
    logic [`EXU_XLEN-1:0]   mp_npc_q;

    assign accept_o = in_valid_i && in_ready_i;
    assign is_mem   = (in_instr_i.cls == CLS_MEM);
    assign is_jbr   = (in_instr_i.cls == CLS_JBR);
    assign is_store = is_mem && in_instr_i.op.mem.store;

    // Address generation always adds
    assign alu_op = is_mem ? ALS_ADD : in_instr_i.op.als;

    exu_alu u_alu (
        .a_i      (in_instr_i.rs1),
        .b_i      (in_instr_i.rs2),
        .op_i     (alu_op),
        .word_i   (in_instr_i.word && (in_instr_i.cls == CLS_ALU)),
        .result_o (alu_res)
    );

    // =================================================================
    // Next PC and mispredict
    // =================================================================
    assign taken    = is_jbr && !(in_instr_i.jbr == JBR_BRANCH && !alu_res[0]);
    assign true_npc = taken ? (in_instr_i.jbr_base + in_instr_i.imm) :
                      (in_instr_i.pc + (in_instr_i.compressed ? `EXU_XLEN'(`EXU_CLEN) :
                                                                `EXU_XLEN'(`EXU_ILEN)));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mp_valid_q <= 1'b0;
        end else begin
            mp_valid_q <= accept_o && is_jbr && (true_npc != in_instr_i.npc);
        end
    end

    always_ff @(posedge clk_i) begin
        mp_pc_q  <= in_instr_i.pc;
        mp_npc_q <= true_npc;
    end

    assign mispred_o = '{valid: mp_valid_q, pc: mp_pc_q, npc: mp_npc_q};

    // =================================================================
    // Memory request and slot to MEM
    // =================================================================
    assign offset = alu_res[`EXU_OFFS_W-1:0];

    always_comb begin
        case (in_instr_i.op.mem.size)
            SIZE_BYTE: strb_base = `EXU_STRB_W'(1);
            SIZE_HALF: strb_base = `EXU_STRB_W'(3);
            SIZE_WORD: strb_base = `EXU_STRB_W'(15);
            default:   strb_base = '1;
        endcase
    end

    always_comb begin
        req_o.valid = accept_o && is_mem;
        req_o.we    = is_store;
        req_o.addr  = alu_res;
        req_o.wdata = in_instr_i.st_data << {offset, 3'b000};
        req_o.strb  = strb_base << offset;
        req_o.size  = in_instr_i.op.mem.size;
    end

    // Stores never write a register
    always_comb begin
        slot_o.ld_en   = is_mem && !in_instr_i.op.mem.store;
        slot_o.rd_en   = in_instr_i.rd_en && !is_store;
        slot_o.rd_idx  = in_instr_i.rd_idx;
        slot_o.result  = alu_res;
        slot_o.ld_desc = in_instr_i.op.mem;
        slot_o.offset  = offset;
    end

endmodule

/* verilog/exu_mem_stage.sv */
// ======================================================================
// MEM stage: holds one instruction until its memory reply hits,
// replays the request on a miss and captures load data on the hit
// ======================================================================
`timescale 1ns/10ps
`include "exu_cfg.svh"

module exu_mem_stage
    import exu_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 accept_i,
    input  mem_slot_t            slot_i,
    input  dmem_req_t            req_i,
    input  logic                 kill_i,
    input  logic                 dmem_hit_i,
    input  logic [`EXU_XLEN-1:0] dmem_rdata_i,
    output logic                 ready_o,
    output logic                 recall_o,
    output dmem_req_t            saved_req_o,
    output logic                 leave_o,
    output mem_slot_t            slot_o,
    output logic [`EXU_XLEN-1:0] rdata_o
);

    logic                 occ_q;
    logic                 pend_q;
    logic                 occ_live;
    logic                 miss;
    mem_slot_t            slot_q;
    dmem_req_t            req_q;
    logic [`EXU_XLEN-1:0] rdata_q;

    // =================================================================
    // Occupancy and miss control
    // =================================================================

    // Kill drops the occupant in this very cycle
    assign occ_live = occ_q && !kill_i;

    // A request went out last cycle and its reply has no hit
    assign miss = pend_q && !dmem_hit_i;

    // Replay while missing, unless cancelled
    assign recall_o = occ_live && miss;
    assign leave_o  = occ_live && !miss;

    // Free slot, or the occupant moves on to WB now
    assign ready_o = !occ_live || leave_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            occ_q  <= 1'b0;
            pend_q <= 1'b0;
        end else begin
            // Either a new instruction enters or the current one stays
            occ_q  <= accept_i || recall_o;
            // Any request sent this cycle, fresh or replayed
            pend_q <= req_i.valid || recall_o;
        end
    end

    // =================================================================
    // Payload
    // =================================================================
    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            slot_q <= slot_i;
            req_q  <= req_i;
        end
    end

    // Read data only on a real hit of our own request
    always_ff @(posedge clk_i) begin
        if (pend_q && dmem_hit_i) begin
            rdata_q <= dmem_rdata_i;
        end
    end

    assign saved_req_o = req_q;
    assign slot_o      = slot_q;
    assign rdata_o     = rdata_q;

endmodule

/* verilog/exu_wb_stage.sv */
// ======================================================================
// WB stage: aligns and extends load data, drives the register write
// ======================================================================
`timescale 1ns/10ps
`include "exu_cfg.svh"

module exu_wb_stage
    import exu_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 leave_i,
    input  mem_slot_t            slot_i,
    input  logic [`EXU_XLEN-1:0] rdata_i,
    output wb_t                  wb_o
);

    logic                      val_q;
    mem_slot_t                 slot_q;
    logic [`EXU_XLEN-1:0]      shifted;
    logic [`EXU_XLEN-1:0]      ld_data;
    logic                      sext;
    logic                      we_q;
    logic [`EXU_REG_IDX_W-1:0] idx_q;
    logic [`EXU_XLEN-1:0]      data_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            val_q <= 1'b0;
            we_q  <= 1'b0;
        end else begin
            val_q <= leave_i;
            we_q  <= val_q && slot_q.rd_en;
        end
    end

    always_ff @(posedge clk_i) begin
        if (leave_i) begin
            slot_q <= slot_i;
        end
    end

    // Move the addressed lane down to bit 0
    assign shifted = rdata_i >> {slot_q.offset, 3'b000};
    assign sext    = slot_q.ld_desc.sign_ext;

    always_comb begin
        case (slot_q.ld_desc.size)
            SIZE_BYTE: ld_data = {{(`EXU_XLEN-8){sext & shifted[7]}}, shifted[7:0]};
            SIZE_HALF: ld_data = {{(`EXU_XLEN-16){sext & shifted[15]}}, shifted[15:0]};
            SIZE_WORD: ld_data = {{(`EXU_XLEN-32){sext & shifted[31]}}, shifted[31:0]};
            default:   ld_data = shifted;
        endcase
    end

    // Register file write port
    always_ff @(posedge clk_i) begin
        idx_q  <= slot_q.rd_idx;
        data_q <= slot_q.ld_en ? ld_data : slot_q.result;
    end

    assign wb_o = '{we: we_q, idx: idx_q, data: data_q};

endmodule

/* verilog/exu_top.sv */
// ======================================================================
// Execute back end top: EX0, MEM and WB with the data memory port
// ======================================================================
`timescale 1ns/10ps
`include "exu_cfg.svh"

module exu_top
    import exu_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 in_valid_i,
    input  exu_instr_t           in_instr_i,
    output logic                 in_ready_o,
    input  logic                 kill_i,
    output dmem_req_t            dmem_req_o,
    output logic                 dmem_kill_o,
    input  logic                 dmem_hit_i,
    input  logic [`EXU_XLEN-1:0] dmem_rdata_i,
    output wb_t                  wb_o,
    output mispred_t             mispred_o
);

    logic                 mem_ready;
    logic                 accept;
    logic                 recall;
    logic                 leave;
    mem_slot_t            ex_slot;
    mem_slot_t            mem_slot;
    dmem_req_t            ex_req;
    dmem_req_t            saved_req;
    logic [`EXU_XLEN-1:0] mem_rdata;

    assign in_ready_o  = mem_ready;
    assign dmem_kill_o = kill_i;

    // Replay the saved request while MEM is missing
    assign dmem_req_o = recall ? saved_req : ex_req;

    exu_ex_stage u_ex (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .in_valid_i (in_valid_i),
        .in_instr_i (in_instr_i),
        .in_ready_i (mem_ready),
        .slot_o     (ex_slot),
        .accept_o   (accept),
        .req_o      (ex_req),
        .mispred_o  (mispred_o)
    );

    exu_mem_stage u_mem (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .accept_i     (accept),
        .slot_i       (ex_slot),
        .req_i        (ex_req),
        .kill_i       (kill_i),
        .dmem_hit_i   (dmem_hit_i),
        .dmem_rdata_i (dmem_rdata_i),
        .ready_o      (mem_ready),
        .recall_o     (recall),
        .saved_req_o  (saved_req),
        .leave_o      (leave),
        .slot_o       (mem_slot),
        .rdata_o      (mem_rdata)
    );

    exu_wb_stage u_wb (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .leave_i (leave),
        .slot_i  (mem_slot),
        .rdata_i (mem_rdata),
        .wb_o    (wb_o)
    );

endmodule

/* verification/exu_props.sv */
// ======================================================================
// Concurrent assertions on the execute back end, bound to its top
// ======================================================================
`timescale 1ns/10ps

module exu_props
    import exu_pkg::*;
(
    input logic       clk_i,
    input logic       rst_n_i,
    input logic       in_valid_i,
    input exu_instr_t in_instr_i,
    input logic       in_ready_o,
    input logic       recall_i,
    input dmem_req_t  dmem_req_o,
    input wb_t        wb_o,
    input mispred_t   mispred_o
);

    // Quiet outputs while reset is held
    assert property (@(posedge clk_i)
        !rst_n_i |-> !wb_o.we && !dmem_req_o.valid && !mispred_o.valid)
        else $error("Output active during reset");

    // Replayed request equals the one sent a cycle earlier
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        recall_i |-> dmem_req_o.addr == $past(dmem_req_o.addr) &&
                     dmem_req_o.wdata == $past(dmem_req_o.wdata))
        else $error("Recalled request differs from the previous one");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mispred_o.valid |-> $past(in_valid_i && in_ready_o && in_instr_i.cls == CLS_JBR))
        else $error("Mispredict without an accepted jump or branch");

endmodule

bind exu_top exu_props u_props (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_valid_i (in_valid_i),
    .in_instr_i (in_instr_i),
    .in_ready_o (in_ready_o),
    .recall_i   (recall),
    .dmem_req_o (dmem_req_o),
    .wb_o       (wb_o),
    .mispred_o  (mispred_o)
);

/* verification/exu_tb.sv */
// ======================================================================
// Testbench of the execute back end: table driven stimulus, memory
// model with random misses, in-order writeback scoreboard
// ======================================================================
`timescale 1ns/10ps
`include "exu_cfg.svh"

module exu_tb
    import exu_pkg::*;
;
    localparam int MAX_ENTRIES = 96;

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 in_valid_i;
    exu_instr_t           in_instr_i;
    logic                 in_ready_o;
    logic                 kill_i;
    dmem_req_t            dmem_req_o;
    logic                 dmem_kill_o;
    logic                 dmem_hit_i;
    logic [`EXU_XLEN-1:0] dmem_rdata_i;
    wb_t                  wb_o;
    mispred_t             mispred_o;

    // Stimulus table with expected results
    exu_instr_t           t_instr [MAX_ENTRIES];
    string                t_name  [MAX_ENTRIES];
    bit                   t_kill  [MAX_ENTRIES];
    bit                   t_we    [MAX_ENTRIES];
    logic [`EXU_XLEN-1:0] t_data  [MAX_ENTRIES];
    bit                   t_mp    [MAX_ENTRIES];
    logic [`EXU_XLEN-1:0] t_npc   [MAX_ENTRIES];
    int                   n_entries;

    logic [7:0]           ref_mem [256];
    logic [7:0]           dmem    [256];
    integer               seed = 3;
    int                   mismatches;
    int                   other_errors;
    int                   stall_cycles;
    int                   cycles;
    int                   limit;
    string                sb_name [$];
    logic [`EXU_XLEN+4:0] sb_exp  [$];
    bit                   mp_armed;
    bit                   mp_exp;
    logic [`EXU_XLEN-1:0] mp_pc;
    logic [`EXU_XLEN-1:0] mp_npc;
    string                mp_name;
    bit                   rsp_pend;
    dmem_req_t            rsp_req;

    exu_top DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a * 29) ^ 8'hA5;
    endfunction

    // Reference ALU, written from the operation rules
    function automatic logic [63:0] ref_alu(input als_op_e op, input bit word,
                                            input logic [63:0] a, input logic [63:0] b);
        logic [31:0] w;
        if (word && op inside {ALS_ADD, ALS_SUB, ALS_SLL, ALS_SRL, ALS_SRA}) begin
            case (op)
                ALS_ADD: w = a[31:0] + b[31:0];
                ALS_SUB: w = a[31:0] - b[31:0];
                ALS_SLL: w = a[31:0] << b[4:0];
                ALS_SRL: w = a[31:0] >> b[4:0];
                default: w = $signed(a[31:0]) >>> b[4:0];
            endcase
            return {{32{w[31]}}, w};
        end
        case (op)
            ALS_ADD:  return a + b;
            ALS_SUB:  return a - b;
            ALS_SLL:  return a << b[5:0];
            ALS_SRL:  return a >> b[5:0];
            ALS_SRA:  return $signed(a) >>> b[5:0];
            ALS_XOR:  return a ^ b;
            ALS_OR:   return a | b;
            ALS_AND:  return a & b;
            ALS_SEQ:  return 64'(a == b);
            ALS_SNE:  return 64'(a != b);
            ALS_SLT:  return 64'($signed(a) < $signed(b));
            ALS_SGE:  return 64'($signed(a) >= $signed(b));
            ALS_SLTU: return 64'(a < b);
            default:  return 64'(a >= b);
        endcase
    endfunction

    function automatic exu_instr_t blank_instr();
        exu_instr_t ins;
        ins = '0;
        ins.pc  = 64'h1000 + 64'(n_entries * 4);
        ins.npc = ins.pc + 4;
        return ins;
    endfunction

    task automatic push_entry(input string name, input exu_instr_t ins, input bit kill,
                              input bit we, input logic [63:0] data,
                              input bit mp, input logic [63:0] npc);
        t_name[n_entries]  = name;
        t_instr[n_entries] = ins;
        t_kill[n_entries]  = kill;
        t_we[n_entries]    = we && !kill;
        t_data[n_entries]  = data;
        t_mp[n_entries]    = mp;
        t_npc[n_entries]   = npc;
        n_entries++;
    endtask

    task automatic add_alu(input string name, input als_op_e op, input bit word,
                           input logic [63:0] a, input logic [63:0] b);
        exu_instr_t ins;
        ins = blank_instr();
        ins.cls    = CLS_ALU;
        ins.op.als = op;
        ins.word   = word;
        ins.rs1    = a;
        ins.rs2    = b;
        ins.rd_en  = 1'b1;
        ins.rd_idx = 5'(n_entries + 1);
        push_entry(name, ins, 1'b0, 1'b1, ref_alu(op, word, a, b), 1'b0, '0);
    endtask

    // Branch when kind is JBR_BRANCH, otherwise a linking jump
    task automatic add_jbr(input string name, input jbr_kind_e kind, input als_op_e op,
                           input logic [63:0] a, input logic [63:0] b,
                           input logic [63:0] base, input logic [63:0] npc, input bit comp);
        exu_instr_t ins;
        logic [63:0] target;
        logic [63:0] cmp_res;
        bit taken;
        ins = blank_instr();
        ins.cls = CLS_JBR;
        ins.jbr = kind;
        ins.compressed = comp;
        ins.jbr_base = base;
        ins.imm = 64'h40;
        ins.npc = npc;
        ins.rd_idx = 5'(n_entries + 1);
        if (kind == JBR_BRANCH) begin
            ins.op.als = op;
            ins.rs1 = a;
            ins.rs2 = b;
            cmp_res = ref_alu(op, 1'b0, a, b);
            taken = cmp_res[0];
        end else begin
            ins.op.als = ALS_ADD;
            ins.rs1 = ins.pc;
            ins.rs2 = comp ? 64'd2 : 64'd4;
            ins.rd_en = 1'b1;
            taken = 1'b1;
        end
        target = taken ? base + 64'h40 : ins.pc + (comp ? 64'd2 : 64'd4);
        push_entry(name, ins, 1'b0, ins.rd_en, ins.pc + ins.rs2, target != npc, target);
    endtask

    task automatic add_mem(input string name, input bit store, input size_e size,
                           input bit sext, input logic [63:0] addr,
                           input logic [63:0] data, input bit kill);
        exu_instr_t ins;
        logic [63:0] exp;
        int nb;
        ins = blank_instr();
        ins.cls    = CLS_MEM;
        ins.op.mem = '{store: store, sign_ext: sext, size: size};
        ins.rs1    = addr & ~64'h7;
        ins.rs2    = addr & 64'h7;
        ins.st_data = data;
        ins.rd_en  = !store;
        ins.rd_idx = 5'(n_entries + 1);
        nb = 1 << size;
        exp = '0;
        for (int i = 0; i < nb; i++) begin
            if (store && !kill) ref_mem[addr[7:0] + i] = data[8*i +: 8];
            exp[8*i +: 8] = ref_mem[addr[7:0] + i];
        end
        if (sext && nb < 8 && exp[8*nb-1]) exp = exp | (~64'h0 << (8*nb));
        push_entry(name, ins, kill, !store, exp, 1'b0, '0);
    endtask

    // =================================================================
    // Memory model: reply one cycle after each request
    // =================================================================
    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_pend = 1'b0;
            dmem_hit_i <= 1'b0;
            dmem_rdata_i <= '0;
        end else begin
            if (rsp_pend && dmem_hit_i && rsp_req.we && !dmem_kill_o) begin
                for (int i = 0; i < 8; i++)
                    if (rsp_req.strb[i])
                        dmem[{rsp_req.addr[7:3], 3'(i)}] = rsp_req.wdata[8*i +: 8];
            end
            rsp_pend = dmem_req_o.valid;
            rsp_req  = dmem_req_o;
            dmem_hit_i <= dmem_req_o.valid && ({$random(seed)} % 3 != 0);
            for (int i = 0; i < 8; i++)
                dmem_rdata_i[8*i +: 8] <= dmem[{dmem_req_o.addr[7:3], 3'(i)}];
        end
    end

    // Writeback scoreboard and mispredict check
    always @(negedge clk_i) begin
        if (rst_n_i && !in_ready_o) stall_cycles++;
        if (wb_o.we) begin
            if (sb_exp.size() == 0) begin
                $display("Writeback to x%0d with no instruction pending", wb_o.idx);
                other_errors++;
            end else if (sb_exp[0] != {wb_o.idx, wb_o.data}) begin
                $display("MISMATCH %s expected %h actual %h", sb_name[0], sb_exp[0],
                         {wb_o.idx, wb_o.data});
                mismatches++;
            end
            if (sb_exp.size() > 0) begin
                void'(sb_exp.pop_front());
                void'(sb_name.pop_front());
            end
        end
        if (mp_armed) begin
            mp_armed = 1'b0;
            if (mispred_o.valid != mp_exp ||
                (mp_exp && (mispred_o.npc != mp_npc || mispred_o.pc != mp_pc))) begin
                $display("MISMATCH %s expected %0b/%h/%h actual %0b/%h/%h", mp_name,
                         mp_exp, mp_pc, mp_npc, mispred_o.valid, mispred_o.pc,
                         mispred_o.npc);
                mismatches++;
            end
        end else if (mispred_o.valid) begin
            $display("Mispredict raised without a jump or branch accepted");
            other_errors++;
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > limit) begin
            $display("Run stopped after %0d cycles, pipeline did not drain", cycles);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        rst_n_i = 1'b0;
        in_valid_i = 1'b0;
        in_instr_i = '0;
        kill_i = 1'b0;
        limit = 10000;
        for (int a = 0; a < 256; a++) begin
            dmem[a] = fill_byte(a);
            ref_mem[a] = fill_byte(a);
        end
        for (int op = 0; op < 14; op++) begin
            add_alu($sformatf("alu op %0d", op), als_op_e'(op), 1'b0,
                    {$random(seed), $random(seed)}, {$random(seed), $random(seed)});
            add_alu($sformatf("alu word op %0d", op), als_op_e'(op), 1'b1,
                    {$random(seed), $random(seed)}, {$random(seed), $random(seed)});
        end
        add_alu("seq equal", ALS_SEQ, 1'b0, 64'h1234, 64'h1234);
        add_alu("sraw negative", ALS_SRA, 1'b1, 64'h8000_0000, 64'd4);
        add_jbr("jal predicted", JBR_JAL, ALS_ADD, 0, 0, 64'h2000, 64'h2040, 1'b0);
        add_jbr("jal wrong npc", JBR_JAL, ALS_ADD, 0, 0, 64'h2000, 64'h3000, 1'b0);
        add_jbr("jalr compressed", JBR_JALR, ALS_ADD, 0, 0, 64'h5500, 64'h0, 1'b1);
        add_jbr("beq taken", JBR_BRANCH, ALS_SEQ, 7, 7, 64'h800, 64'h1000, 1'b0);
        add_jbr("bne not taken", JBR_BRANCH, ALS_SNE, 7, 7, 64'h800, 64'h10cc, 1'b0);
        add_jbr("blt taken ok", JBR_BRANCH, ALS_SLT, -5, 3, 64'h900, 64'h940, 1'b0);
        add_jbr("bgeu compressed", JBR_BRANCH, ALS_SGEU, 1, 3, 64'h900, 64'h940, 1'b1);
        add_mem("sd", 1'b1, SIZE_DOUBLE, 1'b0, 64'h40, 64'h8877_6655_4433_2211, 1'b0);
        add_mem("sb", 1'b1, SIZE_BYTE, 1'b0, 64'h49, 64'hF3, 1'b0);
        add_mem("sh", 1'b1, SIZE_HALF, 1'b0, 64'h4A, 64'h9ABC, 1'b0);
        add_mem("sw", 1'b1, SIZE_WORD, 1'b0, 64'h4C, 64'hDEAD_BEEF, 1'b0);
        add_mem("ld", 1'b0, SIZE_DOUBLE, 1'b0, 64'h40, 0, 1'b0);
        add_mem("ld second", 1'b0, SIZE_DOUBLE, 1'b0, 64'h48, 0, 1'b0);
        add_mem("lb", 1'b0, SIZE_BYTE, 1'b1, 64'h49, 0, 1'b0);
        add_mem("lbu", 1'b0, SIZE_BYTE, 1'b0, 64'h47, 0, 1'b0);
        add_mem("lh", 1'b0, SIZE_HALF, 1'b1, 64'h4A, 0, 1'b0);
        add_mem("lhu", 1'b0, SIZE_HALF, 1'b0, 64'h42, 0, 1'b0);
        add_mem("lw", 1'b0, SIZE_WORD, 1'b1, 64'h4C, 0, 1'b0);
        add_mem("lwu", 1'b0, SIZE_WORD, 1'b0, 64'h4C, 0, 1'b0);
        add_mem("sd killed", 1'b1, SIZE_DOUBLE, 1'b0, 64'h60, 64'h1111_2222_3333_4444, 1'b1);
        add_mem("lw killed", 1'b0, SIZE_WORD, 1'b1, 64'h44, 0, 1'b1);
        add_mem("ld after kill", 1'b0, SIZE_DOUBLE, 1'b0, 64'h60, 0, 1'b0);
        add_alu("add after memory", ALS_ADD, 1'b0, 64'h10, 64'h20);
        limit = n_entries * 12 + 4;

        // Reset, idle outputs and ready afterwards
        repeat (4) begin
            @(negedge clk_i);
            if (wb_o.we || dmem_req_o.valid || mispred_o.valid) begin
                $display("Output active during reset");
                other_errors++;
            end
        end
        @(posedge clk_i);
        rst_n_i <= 1'b1;
        repeat (2) begin
            @(negedge clk_i);
            if (!in_ready_o || wb_o.we || dmem_req_o.valid) begin
                $display("Pipeline not idle and ready after reset");
                other_errors++;
            end
        end

        @(posedge clk_i);
        in_valid_i <= 1'b1;
        in_instr_i <= t_instr[0];
        for (int i = 0; i < n_entries; i++) begin
            do @(negedge clk_i); while (!in_ready_o);
            // Fresh request from EX0 for the instruction about to be accepted
            if (dmem_req_o.valid != (t_instr[i].cls == CLS_MEM) ||
                (dmem_req_o.valid && dmem_req_o.size != t_instr[i].op.mem.size)) begin
                $display("MISMATCH %s expected request %0b/%0d actual %0b/%0d", t_name[i],
                         t_instr[i].cls == CLS_MEM, t_instr[i].op.mem.size,
                         dmem_req_o.valid, dmem_req_o.size);
                mismatches++;
            end
            @(posedge clk_i);
            if (t_we[i]) begin
                sb_name.push_back(t_name[i]);
                sb_exp.push_back({t_instr[i].rd_idx, t_data[i]});
            end
            if (t_instr[i].cls == CLS_JBR) begin
                mp_armed = 1'b1;
                mp_exp   = t_mp[i];
                mp_pc    = t_instr[i].pc;
                mp_npc   = t_npc[i];
                mp_name  = t_name[i];
            end
            if (t_kill[i]) begin
                kill_i <= 1'b1;
                in_valid_i <= 1'b0;
                @(posedge clk_i);
                kill_i <= 1'b0;
            end
            in_valid_i <= (i + 1 < n_entries);
            if (i + 1 < n_entries) in_instr_i <= t_instr[i+1];
        end

        while (sb_exp.size() > 0) @(negedge clk_i);
        repeat (4) @(negedge clk_i);
        if (stall_cycles == 0) begin
            $display("Ready never dropped, no memory miss was exercised");
            other_errors++;
        end
        $display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
verilog/exu_pkg.sv
verilog/exu_alu.sv
verilog/exu_ex_stage.sv
verilog/exu_mem_stage.sv
verilog/exu_wb_stage.sv
verilog/exu_top.sv
verification/exu_props.sv
verification/exu_tb.sv
